// File: rvseed_mem.f
source/rv_core_pkg.sv
source/rd_bus_pkg.sv
source/rd_req_if.sv
source/load_format.sv
source/mem_stage.sv
source/rd_bridge.sv
source/rvseed_mem.sv
bench/rd_mem_model.sv
bench/rvseed_mem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module rvseed_mem_tb -f rvseed_mem.f -o rvseed_mem_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/rvseed_mem_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// File: bench/rvseed_mem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rvseed_mem_tb
    import rv_core_pkg::*, rd_bus_pkg::*;
();

    typedef struct packed {
        load_kind_t kind;
        xword_t     src1;
        xword_t     src2;
        xword_t     result;
        logic       bad_id; // model sends a foreign-id beat first
    } row_t;

    localparam int n_rows         = 33;
    localparam int timeout_cycles = n_rows * 20;

    row_t rows [n_rows] = '{
        '{kind_none, 64'h10, 64'h20, 64'h0123_4567_89ab_cdef, 1'b0},
        '{kind_lb, 64'h1000, 64'h0, 64'h0, 1'b0},
        '{kind_lb, 64'h1000, 64'h1, 64'h0, 1'b0},
        '{kind_lb, 64'h1000, 64'h2, 64'h0, 1'b0},
        '{kind_lb, 64'h1000, 64'h3, 64'h0, 1'b0},
        '{kind_lb, 64'h1000, 64'h4, 64'h0, 1'b0},
        '{kind_lb, 64'h1000, 64'h5, 64'h0, 1'b0},
        '{kind_lb, 64'h1000, 64'h6, 64'h0, 1'b0},
        '{kind_lb, 64'h1000, 64'h7, 64'h0, 1'b0},
        '{kind_lbu, 64'h1000, 64'h0, 64'h0, 1'b0},
        '{kind_lbu, 64'h1000, 64'h1, 64'h0, 1'b0},
        '{kind_lbu, 64'h1000, 64'h2, 64'h0, 1'b0},
        '{kind_lbu, 64'h1000, 64'h3, 64'h0, 1'b0},
        '{kind_lbu, 64'h1000, 64'h4, 64'h0, 1'b0},
        '{kind_lbu, 64'h1000, 64'h5, 64'h0, 1'b0},
        '{kind_lbu, 64'h1000, 64'h6, 64'h0, 1'b0},
        '{kind_lbu, 64'h1000, 64'h7, 64'h0, 1'b0},
        '{kind_lh, 64'h3a40, 64'h0, 64'h0, 1'b0},
        '{kind_lh, 64'h3a40, 64'h2, 64'h0, 1'b0},
        '{kind_lh, 64'h3a40, 64'h4, 64'h0, 1'b0},
        '{kind_lh, 64'h3a40, 64'h6, 64'h0, 1'b0},
        '{kind_lhu, 64'h3a40, 64'h0, 64'h0, 1'b0},
        '{kind_lhu, 64'h3a40, 64'h2, 64'h0, 1'b0},
        '{kind_lhu, 64'h3a40, 64'h4, 64'h0, 1'b0},
        '{kind_lhu, 64'h3a40, 64'h6, 64'h0, 1'b0},
        '{kind_lw, 64'h1010, 64'hffff_ffff_ffff_fff0, 64'h0, 1'b0}, // negative offset
        '{kind_lw, 64'h1000, 64'h4, 64'h0, 1'b0},
        '{kind_lwu, 64'h1000, 64'h0, 64'h0, 1'b0},
        '{kind_lwu, 64'h1000, 64'h4, 64'h0, 1'b0},
        '{kind_ld, 64'h7777_0000, 64'h128, 64'h0, 1'b1},
        '{kind_lw, 64'h4400, 64'h4, 64'h0, 1'b1},
        '{kind_ld, 64'h0000_0100_0000_2000, 64'h8, 64'h0, 1'b0}, // bit 40, bus error
        '{kind_none, 64'h0, 64'h0, 64'hffff_0000_ffff_0000, 1'b0}
    };

    logic       clk;
    logic       rst_n;
    logic       ex_valid;
    logic       ex_ready;
    load_kind_t ex_kind;
    xword_t     ex_src1;
    xword_t     ex_src2;
    xword_t     ex_result;
    logic       wb_valid;
    xword_t     wb_data;
    logic       wb_err;
    logic       arvalid;
    logic       arready;
    xword_t     araddr;
    rd_id_t     arid;
    ar_size_t   arsize;
    logic       rvalid;
    logic       rready;
    xword_t     rdata;
    rd_id_t     rid;
    rd_resp_t   rresp;
    logic       inject_bad;

    int word_errors  = 0;
    int flag_errors  = 0;
    int id_errors    = 0;
    int size_errors  = 0;
    int other_errors = 0;
    int wb_pulses    = 0;
    int cycles       = 0;

    rvseed_mem rvseed_mem_i (.*);

    rd_mem_model mem_model_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            wb_pulses++;
        end
    end

    task automatic check_word(input string name, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %h, expected %h", $time, name, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %b, expected %b", $time, name, got, exp);
            flag_errors++;
        end
    endtask

    task automatic check_id(input string name, input rd_id_t got, input rd_id_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %h, expected %h", $time, name, got, exp);
            id_errors++;
        end
    endtask

    task automatic check_size(input string name, input ar_size_t got, input ar_size_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %0d, expected %0d", $time, name, got, exp);
            size_errors++;
        end
    endtask

    // bytes read by each load kind
    function automatic int load_bytes(input load_kind_t kind);
        case (kind)
            kind_lb, kind_lbu: return 1;
            kind_lh, kind_lhu: return 2;
            kind_lw, kind_lwu: return 4;
            default:           return 8;
        endcase
    endfunction

    // value the load should return, built byte by byte from the beat rule
    function automatic xword_t expected_load(input load_kind_t kind, input xword_t addr);
        logic [31:0] line;
        xword_t      beat;
        xword_t      val;
        int          nbytes;
        line   = {addr[31:3], 3'b000};
        beat   = {line ^ 32'h5a5a_a5a5, ~line};
        nbytes = load_bytes(kind);
        val = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = beat[8*(int'(addr[2:0]) + i) +: 8];
        end
        if ((kind == kind_lb || kind == kind_lh || kind == kind_lw) && val[8*nbytes-1]) begin
            val = val | (~xword_t'(0) << (8 * nbytes)); // sign fill
        end
        return val;
    endfunction

    initial begin
        xword_t   addr;
        xword_t   exp_data;
        logic     exp_err;
        ar_size_t exp_size;
        rst_n      = 1'b0;
        ex_valid   = 1'b0;
        ex_kind    = kind_none;
        ex_src1    = '0;
        ex_src2    = '0;
        ex_result  = '0;
        inject_bad = 1'b0;
        repeat (3) begin
            @(negedge clk);
        end
        // values held while rst_n is still low
        check_flag("ex_ready", ex_ready, 1'b1);
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("arvalid", arvalid, 1'b0);
        check_flag("rready", rready, 1'b0);
        rst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            @(negedge clk);
            while (!ex_ready) begin
                @(negedge clk);
            end
            addr       = rows[r].src1 + rows[r].src2;
            ex_valid   = 1'b1;
            ex_kind    = rows[r].kind;
            ex_src1    = rows[r].src1;
            ex_src2    = rows[r].src2;
            ex_result  = rows[r].result;
            inject_bad = rows[r].bad_id;
            @(negedge clk);
            ex_valid = 1'b0;
            if (rows[r].kind == kind_none) begin
                exp_data = rows[r].result;
                exp_err  = 1'b0;
                check_flag("wb_valid", wb_valid, 1'b1); // one cycle after acceptance
            end else begin
                exp_data = expected_load(rows[r].kind, addr);
                exp_err  = addr[40];
                exp_size = ar_size_t'($clog2(load_bytes(rows[r].kind))); // log2 of bytes
                while (!wb_valid) begin
                    check_flag("ex_ready", ex_ready, 1'b0);
                    if (arvalid) begin
                        check_word("araddr", araddr, addr);
                        check_id("arid", arid, rd_id_t'(2));
                        check_size("arsize", arsize, exp_size);
                    end
                    @(negedge clk);
                end
            end
            check_word("wb_data", wb_data, exp_data);
            check_flag("wb_err", wb_err, exp_err);
        end
        repeat (5) begin
            @(negedge clk);
        end
        if (wb_pulses != n_rows) begin
            $display("wrong number of writebacks: %0d for %0d rows", wb_pulses, n_rows);
            other_errors++;
        end
        $display("errors: data %0d, flag %0d, id %0d, size %0d, other %0d",
                 word_errors, flag_errors, id_errors, size_errors, other_errors);
        if (word_errors + flag_errors + id_errors + size_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/rd_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

// read slave with random handshake delays, data derived from the address
module rd_mem_model
    import rv_core_pkg::*, rd_bus_pkg::*;
(
    input  logic     clk,
    input  logic     inject_bad, // one foreign-id beat goes out first
    input  logic     arvalid,
    output logic     arready,
    input  xword_t   araddr,
    input  rd_id_t   arid,
    input  logic     rready,
    output logic     rvalid,
    output xword_t   rdata,
    output rd_id_t   rid,
    output rd_resp_t rresp
);

    // one beat, held until rready is seen ahead of a rising edge
    task automatic send_beat(input rd_id_t id, input xword_t data, input rd_resp_t resp);
        logic taken;
        repeat ($urandom_range(6, 0)) begin
            @(negedge clk);
        end
        rvalid = 1'b1;
        rid    = id;
        rdata  = data;
        rresp  = resp;
        taken  = 1'b0;
        while (!taken) begin
            taken = rready; // rready only moves on rising edges
            @(negedge clk);
        end
        rvalid = 1'b0;
    endtask

    initial begin
        xword_t      addr;
        xword_t      beat;
        rd_id_t      id;
        rd_resp_t    resp;
        logic        bad;
        void'($urandom(32'h9b54_0e27)); // fixed seed for the whole run
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rid       = '0;
        rresp     = resp_okay;
        forever begin
            @(negedge clk);
            if (arvalid) begin
                addr = araddr; // stable while arvalid is high
                id   = arid;
                bad  = inject_bad;
                beat = {{addr[31:3], 3'b000} ^ 32'h5a5a_a5a5, ~{addr[31:3], 3'b000}};
                resp = addr[40] ? resp_slverr : resp_okay;
                repeat ($urandom_range(4, 0)) begin
                    @(negedge clk);
                end
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                if (bad) begin
                    send_beat(~id, ~beat, resp_okay);
                end
                send_beat(id, beat, resp);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rvseed_mem.sv
`timescale 1ns/100ps
`default_nettype none

module rvseed_mem
    import rv_core_pkg::*, rd_bus_pkg::*;
#(
    parameter rd_id_t LOAD_ID = load_id_default
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ex_valid,
    output logic       ex_ready,
    input  load_kind_t ex_kind,
    input  xword_t     ex_src1,
    input  xword_t     ex_src2,
    input  xword_t     ex_result,
    output logic       wb_valid,
    output xword_t     wb_data,
    output logic       wb_err,
    output logic       arvalid,
    input  logic       arready,
    output xword_t     araddr,
    output rd_id_t     arid,
    output ar_size_t   arsize,
    input  logic       rvalid,
    output logic       rready,
    input  xword_t     rdata,
    input  rd_id_t     rid,
    input  rd_resp_t   rresp
);

    mem_op_t ex_op;

    assign ex_op = '{kind: ex_kind, base: ex_src1, offset: ex_src2, result: ex_result};

    rd_req_if rd_req_i ();

    mem_stage mem_stage_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_valid (ex_valid),
        .ex_ready (ex_ready),
        .ex_op    (ex_op),
        .wb_valid (wb_valid),
        .wb_data  (wb_data),
        .wb_err   (wb_err),
        .rd       (rd_req_i.master)
    );

    rd_bridge #(
        .LOAD_ID (LOAD_ID)
    ) rd_bridge_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd      (rd_req_i.slave),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arid    (arid),
        .arsize  (arsize),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rid     (rid),
        .rresp   (rresp)
    );

endmodule

`default_nettype wire

// File: source/rd_bridge.sv
`timescale 1ns/100ps
`default_nettype none

// single-outstanding read master on an axi-style address/data channel pair
module rd_bridge
    import rv_core_pkg::*, rd_bus_pkg::*;
#(
    parameter rd_id_t LOAD_ID = load_id_default
) (
    input  logic     clk,
    input  logic     rst_n,
    rd_req_if.slave  rd,
    output logic     arvalid,
    input  logic     arready,
    output xword_t   araddr,
    output rd_id_t   arid,
    output ar_size_t arsize,
    input  logic     rvalid,
    output logic     rready,
    input  xword_t   rdata,
    input  rd_id_t   rid,
    input  rd_resp_t rresp
);

    logic ar_hs;
    logic r_hs;
    logic r_match;

    assign ar_hs   = arvalid && arready;
    assign r_hs    = rvalid && rready;
    assign r_match = r_hs && (rid == LOAD_ID); // foreign ids just get dropped

    assign arid = LOAD_ID;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            rd.rsp_done <= 1'b0;
        end else begin
            if (rd.req_valid) begin
                arvalid <= 1'b1;
            end else if (ar_hs) begin
                arvalid <= 1'b0;
            end

            // ready only while our read is in flight
            if (ar_hs) begin
                rready <= 1'b1;
            end else if (r_match) begin
                rready <= 1'b0;
            end

            rd.rsp_done <= r_match;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.req_valid) begin
            araddr <= rd.req_addr;
            arsize <= rd.req_size;
        end
        if (r_match) begin
            rd.rsp_data <= rdata;
            rd.rsp_err  <= (rresp == resp_slverr) || (rresp == resp_decerr);
        end
    end

    // memory stage must wait for rsp_done before the next request
    a_single_outstanding : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd.req_valid |-> !arvalid && !rready
    );

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage
    import rv_core_pkg::*, rd_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ex_valid,
    output logic       ex_ready,
    input  mem_op_t    ex_op,
    output logic       wb_valid,
    output xword_t     wb_data,
    output logic       wb_err,
    rd_req_if.master   rd
);

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_req  = 2'd1,
        st_wait = 2'd2,
        st_fin  = 2'd3
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic       accept;
    logic       req_q;
    load_kind_t kind_q;
    xword_t     addr_q;    // effective address
    xword_t     result_q;  // execute result for pass-through
    ar_size_t   size;
    xword_t     align_mask;
    xword_t     load_data;

    assign ex_ready = (state == st_idle);
    assign accept   = ex_valid && ex_ready;

    always_comb begin
        state_nxt = state;
        unique case (state)
            st_idle: begin
                if (ex_valid) begin
                    state_nxt = is_load(ex_op.kind) ? st_req : st_fin;
                end
            end
            st_req: begin
                state_nxt = st_wait; // request pulse goes out now
            end
            st_wait: begin
                if (rd.rsp_done) begin
                    state_nxt = st_fin;
                end
            end
            st_fin: begin
                state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            req_q <= 1'b0;
        end else begin
            state <= state_nxt;
            req_q <= (state == st_req);
        end
    end

    // operands held for the whole instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            kind_q   <= ex_op.kind;
            addr_q   <= ex_op.base + ex_op.offset;
            result_q <= ex_op.result;
        end
    end

    always_comb begin
        unique case (kind_q)
            kind_lb, kind_lbu: size = size_byte;
            kind_lh, kind_lhu: size = size_half;
            kind_lw, kind_lwu: size = size_word;
            default:           size = size_dword;
        endcase
    end

    assign rd.req_valid = req_q;
    assign rd.req_addr  = addr_q;
    assign rd.req_size  = size;

    // beat stays in the bridge until the next load completes
    load_format load_format_i (
        .beat     (rd.rsp_data),
        .byte_off (addr_q[2:0]),
        .kind     (kind_q),
        .data     (load_data)
    );

    assign wb_valid = (state == st_fin);
    assign wb_data  = is_load(kind_q) ? load_data : result_q;
    assign wb_err   = is_load(kind_q) && rd.rsp_err;

    assign align_mask = (xword_t'(1) << size) - xword_t'(1);

    // misaligned loads are not handled by this stage
    a_load_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        accept && is_load(ex_op.kind) |=> (addr_q & align_mask) == '0
    );

endmodule

`default_nettype wire

// File: source/load_format.sv
`timescale 1ns/100ps
`default_nettype none

// picks the addressed lane out of a 64-bit beat and extends it
module load_format
    import rv_core_pkg::*;
(
    input  xword_t     beat,
    input  logic [2:0] byte_off,
    input  load_kind_t kind,
    output xword_t     data
);

    xword_t lane;

    // addressed byte lands in bits 7:0
    assign lane = beat >> {byte_off, 3'b000};

    always_comb begin
        unique case (kind)
            kind_lb: begin
                data = {{56{lane[7]}}, lane[7:0]};
            end
            kind_lbu: begin
                data = {56'd0, lane[7:0]};
            end
            kind_lh: begin
                data = {{48{lane[15]}}, lane[15:0]};
            end
            kind_lhu: begin
                data = {48'd0, lane[15:0]};
            end
            kind_lw: begin
                data = {{32{lane[31]}}, lane[31:0]};
            end
            kind_lwu: begin
                data = {32'd0, lane[31:0]};
            end
            kind_ld: begin
                data = lane; // full beat, offset is zero when aligned
            end
            default: begin
                data = beat; // not a load, value unused
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/rd_req_if.sv
`timescale 1ns/100ps
`default_nettype none

// request/response link between the memory stage and the read bridge
interface rd_req_if
    import rv_core_pkg::*, rd_bus_pkg::*;
();

    // request side, one-cycle pulse starts a read
    logic     req_valid;
    xword_t   req_addr;  // byte address of the load
    ar_size_t req_size;

    // response side, one-cycle pulse with data and error
    logic     rsp_done;
    xword_t   rsp_data;  // raw 64-bit beat
    logic     rsp_err;

    // memory stage end
    modport master (
        output req_valid,
        output req_addr,
        output req_size,
        input  rsp_done,
        input  rsp_data,
        input  rsp_err
    );

    // bus bridge end
    modport slave (
        input  req_valid,
        input  req_addr,
        input  req_size,
        output rsp_done,
        output rsp_data,
        output rsp_err
    );

endinterface

`default_nettype wire

// File: source/rd_bus_pkg.sv
`default_nettype none

package rd_bus_pkg;

    localparam int rd_id_w = 4;

    typedef logic [rd_id_w-1:0] rd_id_t;

    // axi-style response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } rd_resp_t;

    // bytes per beat as log2, same coding as arsize
    typedef logic [2:0] ar_size_t;

    localparam ar_size_t size_byte  = 3'd0;
    localparam ar_size_t size_half  = 3'd1;
    localparam ar_size_t size_word  = 3'd2;
    localparam ar_size_t size_dword = 3'd3;

    localparam rd_id_t load_id_default = 4'd2; // id used for every load

endpackage

`default_nettype wire

// File: source/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] xword_t;

    // load flavours seen by the memory stage, none means pass-through
    typedef enum logic [2:0] {
        kind_none = 3'd0,
        kind_lb   = 3'd1,
        kind_lbu  = 3'd2,
        kind_lh   = 3'd3,
        kind_lhu  = 3'd4,
        kind_lw   = 3'd5,
        kind_lwu  = 3'd6,
        kind_ld   = 3'd7
    } load_kind_t;

    // one instruction handed over by execute, 195 bits
    typedef struct packed {
        load_kind_t kind;
        xword_t     base;   // rs1 value
        xword_t     offset; // sign-extended immediate
        xword_t     result; // alu result for non-loads
    } mem_op_t;

    function automatic logic is_load(load_kind_t k);
        return k != kind_none;
    endfunction

endpackage

`default_nettype wire
